/* acq_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// shared types for the acquisition pipe
//////////////////////////////////////////////////////////////////////

package acq_pkg;

	// one word of the host pipe
	typedef logic [15:0] pipe_word_t;

	// raw adc conversion result
	typedef logic [11:0] adc_sample_t;

	// channel number, upper nibble of a channel word
	typedef logic [3:0] chan_idx_t;

	// frame counter, wraps at 255
	typedef logic [7:0] frame_count_t;

	// saturating event counter
	// used for missed strobes and dropped words
	typedef logic [15:0] event_count_t;

	// one word on its way into the tx fifo
	typedef struct packed {
		logic       valid;
		pipe_word_t data;
	} pipe_beat_t;

	// upper byte of every header word
	localparam logic [7:0] FRAME_MARK = 8'ha3;

	// header word:  FRAME_MARK | frame count
	// channel word: chan_idx   | sample
	// both layouts fill 16 bits exactly

endpackage

`default_nettype wire

/* adc_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module adc_capture
	import acq_pkg::*;
#(
	parameter int N_ADC = 6
) (
	input  logic                    ti_clk_in,
	input  logic                    reset_in,
	input  logic                    frame_start,
	input  adc_sample_t [N_ADC-1:0] adc_data_in,
	input  logic                    chan_advance,
	output pipe_word_t              chan_word
);

	//////////////////////////////////////////////////////////////////////
	// sample latch
	//////////////////////////////////////////////////////////////////////

	// held samples of the current frame
	adc_sample_t [N_ADC-1:0] sample_q;
	// channel being presented
	chan_idx_t chan_idx;
	// sample picked by chan_idx
	adc_sample_t sel_sample;

	// payload only, loaded once per accepted strobe
	always_ff @(posedge ti_clk_in) begin
		if (frame_start) begin
			sample_q <= adc_data_in;
		end
	end

	// index restarts with every frame
	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			chan_idx <= '0;
		end else if (frame_start) begin
			chan_idx <= '0;
		end else if (chan_advance) begin
			chan_idx <= chan_idx + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// channel word
	//////////////////////////////////////////////////////////////////////

	// mux over the valid channels only
	always_comb begin
		sel_sample = '0;
		for (int i = 0; i < N_ADC; i++) begin
			if (chan_idx == chan_idx_t'(i)) begin
				sel_sample = sample_q[i];
			end
		end
	end

	assign chan_word = {chan_idx, sel_sample};

	// assembler must stop stepping at the last channel
	a_advance_in_range: assert property (@(posedge ti_clk_in) disable iff (reset_in)
		chan_advance |-> (chan_idx < chan_idx_t'(N_ADC - 1)))
		else $error("chan_advance stepped past the last channel");

endmodule

`default_nettype wire

/* frame_stamp.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_stamp
	import acq_pkg::*;
(
	input  logic         ti_clk_in,
	input  logic         reset_in,
	input  logic         frame_start,
	input  logic         strobe_missed,
	output pipe_word_t   header_word,
	output event_count_t missed_count
);

	// count of accepted frames, wraps
	frame_count_t frame_count;

	//////////////////////////////////////////////////////////////////////
	// frame counter and header
	//////////////////////////////////////////////////////////////////////

	// header takes the count before the increment
	// so the first frame carries 0
	always_ff @(posedge ti_clk_in) begin
		if (frame_start) begin
			header_word <= {FRAME_MARK, frame_count};
		end
	end

	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			frame_count <= '0;
		end else if (frame_start) begin
			frame_count <= frame_count + 1'b1;
		end
	end

	// missed strobes, stuck at all ones
	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			missed_count <= '0;
		end else if (strobe_missed && (missed_count != '1)) begin
			missed_count <= missed_count + 1'b1;
		end
	end

	// one strobe is either accepted or refused, never both
	a_start_xor_missed: assert property (@(posedge ti_clk_in) disable iff (reset_in)
		!(frame_start && strobe_missed))
		else $error("frame_start and strobe_missed high together");

endmodule

`default_nettype wire

/* frame_assembler.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_assembler
	import acq_pkg::*;
#(
	parameter int N_ADC = 6
) (
	input  logic       ti_clk_in,
	input  logic       reset_in,
	input  logic       sample_strobe_in,
	input  pipe_word_t header_word,
	input  pipe_word_t chan_word,
	output logic       frame_start,
	output logic       strobe_missed,
	output logic       chan_advance,
	output pipe_beat_t beat
);

	//////////////////////////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HEADER,
		ST_SAMPLES
	} asm_state_t;

	localparam chan_idx_t LAST_CHAN = chan_idx_t'(N_ADC - 1);

	asm_state_t cur_state;
	asm_state_t next_state;
	// channel beats sent in this frame
	chan_idx_t  beat_cnt;
	logic       last_chan;

	assign last_chan = (beat_cnt == LAST_CHAN);

	// accept decision lives only here
	assign frame_start   = sample_strobe_in && (cur_state == ST_IDLE);
	assign strobe_missed = sample_strobe_in && (cur_state != ST_IDLE);
	// no step after the last channel
	assign chan_advance  = (cur_state == ST_SAMPLES) && !last_chan;

	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			cur_state <= ST_IDLE;
		end else begin
			cur_state <= next_state;
		end
	end

	always_comb begin
		next_state = cur_state;
		case (cur_state)
			ST_IDLE:    if (frame_start) next_state = ST_HEADER;
			ST_HEADER:  next_state = ST_SAMPLES;
			ST_SAMPLES: if (last_chan) next_state = ST_IDLE;
			default:    next_state = ST_IDLE;
		endcase
	end

	// runs only while channel beats go out
	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			beat_cnt <= '0;
		end else if (cur_state == ST_SAMPLES) begin
			beat_cnt <= beat_cnt + 1'b1;
		end else begin
			beat_cnt <= '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// beat merge
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		beat = '0;
		case (cur_state)
			ST_HEADER:  beat = '{valid: 1'b1, data: header_word};
			ST_SAMPLES: beat = '{valid: 1'b1, data: chan_word};
			default:    beat = '0;
		endcase
	end

	// a valid beat follows an accepted strobe or another valid beat
	a_no_beat_idle: assert property (@(posedge ti_clk_in) disable iff (reset_in)
		beat.valid |-> $past(frame_start || beat.valid))
		else $error("beat valid outside a frame");

endmodule

`default_nettype wire

/* pipe_tx_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_tx_fifo
	import acq_pkg::*;
#(
	parameter int READ_LEN   = 16,
	parameter int FIFO_DEPTH = 64
) (
	input  logic         ti_clk_in,
	input  logic         reset_in,
	input  pipe_beat_t   beat,
	input  logic         pipe_read_in,
	output pipe_word_t   data_out,
	output logic         burst_ready,
	output event_count_t drop_count
);

	//////////////////////////////////////////////////////////////////////
	// internal structures
	//////////////////////////////////////////////////////////////////////

	localparam int AW     = $clog2(FIFO_DEPTH);
	localparam int FILL_W = AW + 1;
	// wide enough for READ_LEN-1 even when READ_LEN is 1
	localparam int CW     = $clog2(READ_LEN + 1);

	typedef enum logic {
		ST_WAIT,
		ST_READ
	} burst_state_t;

	// word storage, no reset
	pipe_word_t mem [FIFO_DEPTH];

	logic [AW-1:0]     wr_ptr;
	logic [AW-1:0]     rd_ptr;
	logic [FILL_W-1:0] fill_count;

	logic push;
	logic pop;
	logic empty;
	logic full;
	// push into a full fifo with no pop to make room
	logic overflow;

	// pops seen in the current burst
	logic [CW-1:0] rd_count;
	logic          burst_done;
	burst_state_t  cur_state;
	burst_state_t  next_state;

	//////////////////////////////////////////////////////////////////////
	// combinational logic
	//////////////////////////////////////////////////////////////////////

	assign empty    = (fill_count == '0);
	assign full     = (fill_count == FILL_W'(FIFO_DEPTH));
	assign push     = beat.valid;
	assign pop      = pipe_read_in && !empty;
	assign overflow = push && full && !pop;

	// first word fall through, head is always on the port
	assign data_out = mem[rd_ptr];

	assign burst_ready = (cur_state == ST_WAIT) && (fill_count >= FILL_W'(READ_LEN));
	assign burst_done  = pop && (rd_count == CW'(READ_LEN - 1));

	//////////////////////////////////////////////////////////////////////
	// circular buffer
	//////////////////////////////////////////////////////////////////////

	// full fifo: wr_ptr sits on the oldest word, so a write overwrites it
	always_ff @(posedge ti_clk_in) begin
		if (push) begin
			mem[wr_ptr] <= beat.data;
		end
	end

	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// overflow drops the oldest word
			if (pop || overflow) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// level holds on overflow
			if (push && !pop && !full) begin
				fill_count <= fill_count + 1'b1;
			end else if (pop && !push) begin
				fill_count <= fill_count - 1'b1;
			end
		end
	end

	// dropped words, saturating
	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			drop_count <= '0;
		end else if (overflow && (drop_count != '1)) begin
			drop_count <= drop_count + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read burst state machine
	//////////////////////////////////////////////////////////////////////

	// count every pop of the burst, first one included
	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			rd_count <= '0;
		end else if (burst_done) begin
			rd_count <= '0;
		end else if (pop) begin
			rd_count <= rd_count + 1'b1;
		end
	end

	always_ff @(posedge ti_clk_in) begin
		if (reset_in) begin
			cur_state <= ST_WAIT;
		end else begin
			cur_state <= next_state;
		end
	end

	always_comb begin
		next_state = cur_state;
		case (cur_state)
			ST_WAIT: if (pop && !burst_done) next_state = ST_READ;
			ST_READ: if (burst_done) next_state = ST_WAIT;
			default: next_state = ST_WAIT;
		endcase
	end

	// host only reads what burst_ready promised
	a_no_pop_empty: assert property (@(posedge ti_clk_in) disable iff (reset_in)
		pipe_read_in |-> !empty)
		else $error("host read from an empty fifo");

endmodule

`default_nettype wire

/* acq_pipe_top.sv */
`timescale 1ns/100ps
`default_nettype none

module acq_pipe_top
	import acq_pkg::*;
#(
	parameter int N_ADC      = 6,
	parameter int READ_LEN   = 16,
	parameter int FIFO_DEPTH = 64
) (
	input  logic                    ti_clk_in,
	input  logic                    reset_in,
	input  logic                    sample_strobe_in,
	input  adc_sample_t [N_ADC-1:0] adc_data_in,
	input  logic                    pipe_read_in,
	output pipe_word_t              data_out,
	output logic                    burst_ready,
	output event_count_t            missed_count,
	output event_count_t            drop_count
);

	//////////////////////////////////////////////////////////////////////
	// block wiring
	//////////////////////////////////////////////////////////////////////

	// accept and refuse pulses from the assembler
	logic       frame_start;
	logic       strobe_missed;
	// step to the next held sample
	logic       chan_advance;
	pipe_word_t header_word;
	pipe_word_t chan_word;
	// merged word stream into the fifo
	pipe_beat_t beat;

	adc_capture #(
		.N_ADC (N_ADC)
	) i_adc_capture (
		.ti_clk_in    (ti_clk_in),
		.reset_in     (reset_in),
		.frame_start  (frame_start),
		.adc_data_in  (adc_data_in),
		.chan_advance (chan_advance),
		.chan_word    (chan_word)
	);

	frame_stamp i_frame_stamp (
		.ti_clk_in     (ti_clk_in),
		.reset_in      (reset_in),
		.frame_start   (frame_start),
		.strobe_missed (strobe_missed),
		.header_word   (header_word),
		.missed_count  (missed_count)
	);

	frame_assembler #(
		.N_ADC (N_ADC)
	) i_frame_assembler (
		.ti_clk_in        (ti_clk_in),
		.reset_in         (reset_in),
		.sample_strobe_in (sample_strobe_in),
		.header_word      (header_word),
		.chan_word        (chan_word),
		.frame_start      (frame_start),
		.strobe_missed    (strobe_missed),
		.chan_advance     (chan_advance),
		.beat             (beat)
	);

	pipe_tx_fifo #(
		.READ_LEN   (READ_LEN),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_pipe_tx_fifo (
		.ti_clk_in    (ti_clk_in),
		.reset_in     (reset_in),
		.beat         (beat),
		.pipe_read_in (pipe_read_in),
		.data_out     (data_out),
		.burst_ready  (burst_ready),
		.drop_count   (drop_count)
	);

endmodule

`default_nettype wire

/* tb_acq_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_acq_pipe
	import acq_pkg::*;
();

	localparam int N_ADC      = 6;
	localparam int READ_LEN   = 16;
	localparam int FIFO_DEPTH = 64;
	// cycle budget per command line
	localparam int LINE_CYCLES = N_ADC + READ_LEN + 8;
	localparam string DATA_FILE = "acq_pipe_testdata.txt";
	// upper byte of a header word
	localparam logic [7:0] HDR_MARK = 8'ha3;
	localparam logic [15:0] LFSR_SEED = 16'd61837;

	logic                    ti_clk_in;
	logic                    reset_in;
	logic                    sample_strobe_in;
	adc_sample_t [N_ADC-1:0] adc_data_in;
	logic                    pipe_read_in;
	pipe_word_t              data_out;
	logic                    burst_ready;
	event_count_t            missed_count;
	event_count_t            drop_count;

	// expected fifo contents with the oldest first
	pipe_word_t   model_q [$];
	frame_count_t model_frame;
	logic [15:0]  lfsr;
	string        cmd_lines [$];
	int           value_errors;
	int           other_errors;
	int           cycle_count = 0;
	int           cycle_limit = 100000;

	acq_pipe_top #(
		.N_ADC      (N_ADC),
		.READ_LEN   (READ_LEN),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_acq_pipe_top (
		.ti_clk_in        (ti_clk_in),
		.reset_in         (reset_in),
		.sample_strobe_in (sample_strobe_in),
		.adc_data_in      (adc_data_in),
		.pipe_read_in     (pipe_read_in),
		.data_out         (data_out),
		.burst_ready      (burst_ready),
		.missed_count     (missed_count),
		.drop_count       (drop_count)
	);

	//////////////////////////////////////////////////////////////////////
	// clock and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		ti_clk_in = 1'b0;
		forever #50 ti_clk_in = ~ti_clk_in;
	end

	always @(posedge ti_clk_in) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the test did not finish within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic fb;
		fb = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], fb};
	endfunction

	// one lfsr step per sample bit
	task automatic random_sample(output adc_sample_t smp);
		smp = '0;
		for (int b = 0; b < 12; b++) begin
			lfsr = lfsr_next(lfsr);
			smp = {smp[10:0], lfsr[0]};
		end
	endtask

	task automatic fill_random();
		adc_sample_t smp;
		for (int k = 0; k < N_ADC; k++) begin
			random_sample(smp);
			adc_data_in[k] = smp;
		end
	endtask

	// inputs change 10 ns after the edge
	task automatic next_cycle();
		@(posedge ti_clk_in);
		#10;
	endtask

	task automatic check_word(input string name, input pipe_word_t got, input pipe_word_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input event_count_t got,
			input event_count_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	// full model fifo loses its oldest word
	task automatic model_push(input pipe_word_t w);
		if (model_q.size() == FIFO_DEPTH) begin
			void'(model_q.pop_front());
		end
		model_q.push_back(w);
	endtask

	// header and channel words from adc_data_in plus an optional refused strobe
	task automatic strobe_frame(input logic with_second);
		int waits;
		model_push({HDR_MARK, model_frame});
		for (int k = 0; k < N_ADC; k++) begin
			model_push({chan_idx_t'(k), adc_data_in[k]});
		end
		model_frame = model_frame + 1'b1;
		sample_strobe_in = 1'b1;
		next_cycle();
		sample_strobe_in = 1'b0;
		waits = N_ADC + 1;
		if (with_second) begin
			next_cycle();
			fill_random();
			sample_strobe_in = 1'b1;
			next_cycle();
			sample_strobe_in = 1'b0;
			waits = N_ADC - 1;
		end
		// assembler idle again and last word in the fifo
		repeat (waits) next_cycle();
		check_level("burst_ready", burst_ready, model_q.size() >= READ_LEN);
	endtask

	task automatic read_burst();
		pipe_word_t exp;
		if (model_q.size() < READ_LEN) begin
			$display("read burst skipped, the model holds only %0d words", model_q.size());
			other_errors++;
		end else begin
			check_level("burst_ready", burst_ready, 1'b1);
			pipe_read_in = 1'b1;
			for (int i = 0; i < READ_LEN; i++) begin
				// low for the rest of the burst
				if (i > 0) begin
					check_level("burst_ready", burst_ready, 1'b0);
				end
				exp = model_q.pop_front();
				check_word("data_out", data_out, exp);
				next_cycle();
			end
			pipe_read_in = 1'b0;
			check_level("burst_ready", burst_ready, model_q.size() >= READ_LEN);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// command sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int          fd;
		int          code;
		int          n;
		int          budget;
		string       line;
		byte         cmd;
		logic [31:0] vals [N_ADC];
		logic [31:0] exp_missed;
		logic [31:0] exp_drop;

		reset_in         = 1'b1;
		sample_strobe_in = 1'b0;
		adc_data_in      = '0;
		pipe_read_in     = 1'b0;
		lfsr             = LFSR_SEED;
		model_frame      = '0;
		value_errors     = 0;
		other_errors     = 0;
		budget           = 0;

		// keep command lines and skip comments and blanks
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("could not open the data file %s", DATA_FILE);
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 0) begin
					cmd = line.getc(0);
					if (cmd == "S" || cmd == "B" || cmd == "O" || cmd == "R" || cmd == "C") begin
						cmd_lines.push_back(line);
						n = 1;
						if (cmd == "O") begin
							code = $sscanf(line, "O %d", n);
						end
						budget += n * LINE_CYCLES;
					end
				end
			end
			$fclose(fd);
		end
		// reset cycles and a margin on top
		cycle_limit = budget + 40;

		repeat (10) @(posedge ti_clk_in);
		#10;
		reset_in = 1'b0;
		check_level("burst_ready", burst_ready, 1'b0);
		check_count("missed_count", missed_count, '0);
		check_count("drop_count", drop_count, '0);

		foreach (cmd_lines[j]) begin
			line = cmd_lines[j];
			cmd = line.getc(0);
			case (cmd)
				"S": begin
					code = $sscanf(line, "S %h %h %h %h %h %h",
						vals[0], vals[1], vals[2], vals[3], vals[4], vals[5]);
					if (code != N_ADC) begin
						$display("sample line %0d does not hold %0d values", j, N_ADC);
						other_errors++;
					end else begin
						fill_random();
						// zero in the file keeps the random sample
						for (int k = 0; k < N_ADC; k++) begin
							if (vals[k] != 0) begin
								adc_data_in[k] = vals[k][11:0];
							end
						end
						strobe_frame(1'b0);
					end
				end
				"B": begin
					fill_random();
					strobe_frame(1'b1);
				end
				"O": begin
					code = $sscanf(line, "O %d", n);
					repeat (n) begin
						fill_random();
						strobe_frame(1'b0);
					end
				end
				"R": read_burst();
				"C": begin
					code = $sscanf(line, "C %h %h", exp_missed, exp_drop);
					check_count("missed_count", missed_count, event_count_t'(exp_missed));
					check_count("drop_count", drop_count, event_count_t'(exp_drop));
				end
				default: begin
					$display("unknown command on line %0d", j);
					other_errors++;
				end
			endcase
		end

		next_cycle();
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* acq_pipe_testdata.txt */
# S s0 s1 s2 s3 s4 s5 : one sample set in hex, 0 takes a random sample
# B : strobe pair | O n : n frames, no reads | R : one read burst
# C mm dd : expected missed_count and drop_count in hex
C 0000 0000
S 123 456 789 abc def 010
S 0 0 0 0 0 0
S 800 7ff 001 ffe 555 aaa
R
B
C 0001 0000
S 0 0 0 0 0 0
R
B
B
C 0003 0000
R
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S fff 0 0 0 0 fff
R
C 0003 0000
# overflow, newest 64 words kept
O 10
C 0003 000c
R
R
R
R
C 0003 000c
O 12
B
C 0004 0027
R
R
R
R
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 321 654 987 cba fed 0f0
R
C 0004 0027

/* vlog.f */
acq_pkg.sv
adc_capture.sv
frame_stamp.sv
frame_assembler.sv
pipe_tx_fifo.sv
acq_pipe_top.sv
tb_acq_pipe.sv

/* Makefile */
# Verilator build for the acquisition pipe testbench

SIM        = verilator
TOP        = tb_acq_pipe
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
PASS_MSG   = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# fails unless the pass message shows up in the output
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
